/* verilog/core_pkg.sv */
package core_pkg;

   localparam int xlen = 32;

   // major opcodes of the supported subset
   localparam logic [6:0] op_lui    = 7'b0110111;
   localparam logic [6:0] op_jal    = 7'b1101111;
   localparam logic [6:0] op_branch = 7'b1100011;
   localparam logic [6:0] op_load   = 7'b0000011;
   localparam logic [6:0] op_store  = 7'b0100011;
   localparam logic [6:0] op_imm    = 7'b0010011;
   localparam logic [6:0] op_reg    = 7'b0110011;

   typedef logic [4:0]      reg_addr_t;
   typedef logic [xlen-1:0] word_t;

   typedef enum logic [2:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
   } alu_op_e;

   typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4} wb_sel_e;

   typedef enum logic [2:0] {mem_none, mem_lw, mem_lb, mem_lbu, mem_sw, mem_sb} mem_op_e;

   typedef enum logic [1:0] {br_none, br_beq, br_bne, br_jal} br_op_e;

   typedef enum logic [1:0] {fwd_reg, fwd_ex_mem, fwd_mem_wb} fwd_sel_e;

   typedef struct packed {
      word_t pc;
      word_t instr;
      logic  valid;
   } if_id_t;

   typedef struct packed {
      word_t     pc;
      word_t     rs1_val;
      word_t     rs2_val;
      word_t     imm;
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
      alu_op_e   alu_op;
      logic      op1_pc;   // operand a is the pc
      logic      op2_imm;  // operand b is the immediate
      br_op_e    br_op;
      mem_op_e   mem_op;
      wb_sel_e   wb_sel;
      logic      reg_we;
   } id_ex_t;

   typedef struct packed {
      word_t     pc;
      word_t     alu_out;
      word_t     store_val;
      reg_addr_t rd;
      mem_op_e   mem_op;
      wb_sel_e   wb_sel;
      logic      reg_we;
   } ex_mem_t;

   typedef struct packed {
      word_t     pc;
      word_t     alu_out;
      word_t     load_val;
      reg_addr_t rd;
      wb_sel_e   wb_sel;
      logic      reg_we;
   } mem_wb_t;

   typedef struct packed {
      logic [29:0] addr;   // word address
      word_t       wdata;
      logic [3:0]  be;
   } dmem_req_t;

endpackage

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import core_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        stall_i,
   input  logic        flush_i,
   input  logic        br_taken_i,
   input  word_t       br_target_i,
   output logic [29:0] imem_addr_o,
   input  word_t       imem_data_i,
   output if_id_t      if_id_o
);

   word_t  pc_q;
   word_t  pc_next;
   if_id_t if_id_q;

   always_comb begin
      if (br_taken_i)
         pc_next = br_target_i;  // redirect beats a stall
      else if (stall_i)
         pc_next = pc_q;
      else
         pc_next = pc_q + 32'd4;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i)
         pc_q <= '0;
      else
         pc_q <= pc_next;
   end

   assign imem_addr_o = pc_q[31:2];

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i)
         if_id_q <= '0;
      else if (flush_i)
         if_id_q.valid <= 1'b0;  // wrong-path fetch dropped
      else if (!stall_i)
         if_id_q <= '{pc: pc_q, instr: imem_data_i, valid: 1'b1};
   end

   assign if_id_o = if_id_q;

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import core_pkg::*; (
   input  logic    clk_i,
   input  logic    rst_n_i,
   input  if_id_t  if_id_i,
   input  mem_wb_t mem_wb_i,
   input  logic    stall_i,
   input  logic    flush_i,
   output id_ex_t  id_ex_o,
   output word_t   wb_data_o
);

   word_t      rf_q [1:31];  // x0 is not stored
   word_t      instr;
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm_u;
   word_t      imm_j;
   logic       rf_we;
   id_ex_t     id_ex_d;
   id_ex_t     id_ex_q;

   assign instr  = if_id_i.instr;
   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_u = {instr[31:12], 12'b0};
   assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   // writeback source
   always_comb begin
      case (mem_wb_i.wb_sel)
         wb_mem:  wb_data_o = mem_wb_i.load_val;
         wb_pc4:  wb_data_o = mem_wb_i.pc + 32'd4;
         default: wb_data_o = mem_wb_i.alu_out;
      endcase
   end

   assign rf_we = mem_wb_i.reg_we && (mem_wb_i.rd != 5'd0);

   always_ff @(posedge clk_i) begin
      if (rf_we)
         rf_q[mem_wb_i.rd] <= wb_data_o;
   end

   function automatic word_t rf_read(reg_addr_t idx);
      if (idx == 5'd0)
         return '0;
      if (rf_we && mem_wb_i.rd == idx)
         return wb_data_o;  // same-cycle write-through
      return rf_q[idx];
   endfunction

   always_comb begin
      id_ex_d         = '0;
      id_ex_d.pc      = if_id_i.pc;
      id_ex_d.rs1     = instr[19:15];
      id_ex_d.rs2     = instr[24:20];
      id_ex_d.rd      = instr[11:7];
      id_ex_d.rs1_val = rf_read(instr[19:15]);
      id_ex_d.rs2_val = rf_read(instr[24:20]);
      case (opcode)
         op_reg: begin
            id_ex_d.reg_we = 1'b1;
            case (funct3)
               3'b000:  id_ex_d.alu_op = (funct7 == 7'b0100000) ? alu_sub : alu_add;
               3'b010:  id_ex_d.alu_op = alu_slt;
               3'b100:  id_ex_d.alu_op = alu_xor;
               3'b110:  id_ex_d.alu_op = alu_or;
               3'b111:  id_ex_d.alu_op = alu_and;
               default: id_ex_d.reg_we = 1'b0;
            endcase
         end
         op_imm: begin
            id_ex_d.imm     = imm_i;
            id_ex_d.op2_imm = 1'b1;
            id_ex_d.reg_we  = (funct3 == 3'b000);  // addi only
         end
         op_lui: begin
            id_ex_d.imm     = imm_u;
            id_ex_d.op2_imm = 1'b1;
            id_ex_d.alu_op  = alu_pass_b;
            id_ex_d.reg_we  = 1'b1;
         end
         op_load: begin
            id_ex_d.imm     = imm_i;
            id_ex_d.op2_imm = 1'b1;
            id_ex_d.wb_sel  = wb_mem;
            id_ex_d.reg_we  = 1'b1;
            case (funct3)
               3'b010:  id_ex_d.mem_op = mem_lw;
               3'b000:  id_ex_d.mem_op = mem_lb;
               3'b100:  id_ex_d.mem_op = mem_lbu;
               default: id_ex_d.reg_we = 1'b0;
            endcase
         end
         op_store: begin
            id_ex_d.imm     = imm_s;
            id_ex_d.op2_imm = 1'b1;
            if (funct3 == 3'b010)
               id_ex_d.mem_op = mem_sw;
            else if (funct3 == 3'b000)
               id_ex_d.mem_op = mem_sb;
         end
         op_branch: begin
            id_ex_d.imm     = imm_b;
            id_ex_d.op1_pc  = 1'b1;  // alu forms the target
            id_ex_d.op2_imm = 1'b1;
            if (funct3 == 3'b000)
               id_ex_d.br_op = br_beq;
            else if (funct3 == 3'b001)
               id_ex_d.br_op = br_bne;
         end
         op_jal: begin
            id_ex_d.imm     = imm_j;
            id_ex_d.op1_pc  = 1'b1;  // alu forms the target
            id_ex_d.op2_imm = 1'b1;
            id_ex_d.br_op   = br_jal;
            id_ex_d.wb_sel  = wb_pc4;
            id_ex_d.reg_we  = 1'b1;
         end
         default: ;
      endcase
      if (!if_id_i.valid) begin
         id_ex_d.reg_we = 1'b0;
         id_ex_d.mem_op = mem_none;
         id_ex_d.br_op  = br_none;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i)
         id_ex_q <= '0;
      else if (stall_i || flush_i)
         id_ex_q <= '0;  // bubble
      else
         id_ex_q <= id_ex_d;
   end

   assign id_ex_o = id_ex_q;

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  id_ex_t   id_ex_i,
   input  fwd_sel_e fwd_a_i,
   input  fwd_sel_e fwd_b_i,
   input  word_t    ex_fwd_i,
   input  word_t    wb_fwd_i,
   output ex_mem_t  ex_mem_o,
   output logic     br_taken_o,
   output word_t    br_target_o
);

   word_t   rs1_val;
   word_t   rs2_val;
   word_t   op_a;
   word_t   op_b;
   word_t   alu_res;
   logic    equal;
   ex_mem_t ex_mem_q;

   function automatic word_t fwd_mux(fwd_sel_e sel, word_t reg_val, word_t ex_val,
                                     word_t wb_val);
      case (sel)
         fwd_ex_mem: return ex_val;
         fwd_mem_wb: return wb_val;
         default:    return reg_val;
      endcase
   endfunction

   // newest register values first, then the operand choice
   assign rs1_val = fwd_mux(fwd_a_i, id_ex_i.rs1_val, ex_fwd_i, wb_fwd_i);
   assign rs2_val = fwd_mux(fwd_b_i, id_ex_i.rs2_val, ex_fwd_i, wb_fwd_i);
   assign op_a    = id_ex_i.op1_pc ? id_ex_i.pc : rs1_val;
   assign op_b    = id_ex_i.op2_imm ? id_ex_i.imm : rs2_val;

   always_comb begin
      case (id_ex_i.alu_op)
         alu_sub:    alu_res = op_a - op_b;
         alu_and:    alu_res = op_a & op_b;
         alu_or:     alu_res = op_a | op_b;
         alu_xor:    alu_res = op_a ^ op_b;
         alu_slt:    alu_res = word_t'($signed(op_a) < $signed(op_b));
         alu_pass_b: alu_res = op_b;
         default:    alu_res = op_a + op_b;
      endcase
   end

   assign equal = (rs1_val == rs2_val);

   always_comb begin
      case (id_ex_i.br_op)
         br_beq:  br_taken_o = equal;
         br_bne:  br_taken_o = !equal;
         br_jal:  br_taken_o = 1'b1;
         default: br_taken_o = 1'b0;
      endcase
   end

   assign br_target_o = alu_res;  // pc + imm for branches and jal

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ex_mem_q <= '0;
      end else begin
         ex_mem_q.pc        <= id_ex_i.pc;
         ex_mem_q.alu_out   <= alu_res;
         ex_mem_q.store_val <= rs2_val;
         ex_mem_q.rd        <= id_ex_i.rd;
         ex_mem_q.mem_op    <= id_ex_i.mem_op;
         ex_mem_q.wb_sel    <= id_ex_i.wb_sel;
         ex_mem_q.reg_we    <= id_ex_i.reg_we;
      end
   end

   assign ex_mem_o = ex_mem_q;

endmodule

/* verilog/mem_access_unit.sv */
`timescale 1ns/1ps

module mem_access_unit import core_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  ex_mem_t   ex_mem_i,
   output dmem_req_t dmem_req_o,
   output logic      dmem_we_o,
   output logic      dmem_re_o,
   input  word_t     dmem_rdata_i,
   output mem_wb_t   mem_wb_o
);

   logic [1:0] offset;
   logic [7:0] byte_val;
   word_t      load_val;
   mem_wb_t    mem_wb_q;

   assign offset = ex_mem_i.alu_out[1:0];

   always_comb begin
      dmem_req_o.addr  = ex_mem_i.alu_out[31:2];
      dmem_req_o.wdata = ex_mem_i.store_val;
      dmem_req_o.be    = 4'b0000;
      case (ex_mem_i.mem_op)
         mem_sw: dmem_req_o.be = 4'b1111;
         mem_sb: begin
            dmem_req_o.wdata = {4{ex_mem_i.store_val[7:0]}};  // byte in every lane
            dmem_req_o.be    = 4'b0001 << offset;
         end
         default: ;
      endcase
   end

   assign dmem_we_o = ex_mem_i.mem_op inside {mem_sw, mem_sb};
   assign dmem_re_o = ex_mem_i.mem_op inside {mem_lw, mem_lb, mem_lbu};

   assign byte_val = dmem_rdata_i[{offset, 3'b000} +: 8];

   always_comb begin
      case (ex_mem_i.mem_op)
         mem_lb:  load_val = {{24{byte_val[7]}}, byte_val};
         mem_lbu: load_val = {24'b0, byte_val};
         default: load_val = dmem_rdata_i;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i)
         mem_wb_q <= '0;
      else
         mem_wb_q <= '{pc: ex_mem_i.pc, alu_out: ex_mem_i.alu_out, load_val: load_val,
                       rd: ex_mem_i.rd, wb_sel: ex_mem_i.wb_sel, reg_we: ex_mem_i.reg_we};
   end

   assign mem_wb_o = mem_wb_q;

   // no misaligned trap in this core, so word accesses must arrive aligned
   a_word_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (ex_mem_i.mem_op inside {mem_lw, mem_sw}) |-> (offset == 2'b00));

endmodule

/* verilog/hazard_control.sv */
`timescale 1ns/1ps

module hazard_control import core_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  reg_addr_t id_rs1_i,
   input  reg_addr_t id_rs2_i,
   input  id_ex_t    id_ex_i,
   input  ex_mem_t   ex_mem_i,
   input  mem_wb_t   mem_wb_i,
   input  logic      br_taken_i,
   output logic      stall_o,
   output logic      flush_o,
   output fwd_sel_e  fwd_a_o,
   output fwd_sel_e  fwd_b_o
);

   logic load_in_ex;

   function automatic fwd_sel_e fwd_pick(reg_addr_t rs);
      if (rs == 5'd0)
         return fwd_reg;  // x0 never forwarded
      if (ex_mem_i.reg_we && ex_mem_i.rd == rs)
         return fwd_ex_mem;  // youngest writer wins
      if (mem_wb_i.reg_we && mem_wb_i.rd == rs)
         return fwd_mem_wb;
      return fwd_reg;
   endfunction

   always_comb begin
      fwd_a_o = fwd_pick(id_ex_i.rs1);
      fwd_b_o = fwd_pick(id_ex_i.rs2);
   end

   assign load_in_ex = id_ex_i.reg_we && (id_ex_i.wb_sel == wb_mem) && (id_ex_i.rd != 5'd0);
   assign stall_o    = load_in_ex && (id_ex_i.rd == id_rs1_i || id_ex_i.rd == id_rs2_i);
   assign flush_o    = br_taken_i;

   // EX holds a bubble after a flush whatever stall says
   a_flush_wins: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      flush_o |=> (!id_ex_i.reg_we && id_ex_i.mem_op == mem_none && id_ex_i.br_op == br_none));

   // no EX/MEM forward from a load still in flight
   a_fwd_ex_mem: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (fwd_a_o == fwd_ex_mem || fwd_b_o == fwd_ex_mem)
         |-> (ex_mem_i.reg_we && ex_mem_i.wb_sel != wb_mem));

endmodule

/* verilog/core.sv */
`timescale 1ns/1ps

module core import core_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_n_i,
   output logic [29:0] imem_addr_o,
   input  word_t       imem_data_i,
   output dmem_req_t   dmem_req_o,
   output logic        dmem_we_o,
   output logic        dmem_re_o,
   input  word_t       dmem_rdata_i
);

   if_id_t   if_id;
   id_ex_t   id_ex;
   ex_mem_t  ex_mem;
   mem_wb_t  mem_wb;
   word_t    wb_data;    // value written back, also the MEM/WB forward
   word_t    br_target;
   logic     br_taken;
   logic     stall;
   logic     flush;
   fwd_sel_e fwd_a;
   fwd_sel_e fwd_b;

   fetch_stage u_fetch (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .stall_i     (stall),
      .flush_i     (flush),
      .br_taken_i  (br_taken),
      .br_target_i (br_target),
      .imem_addr_o (imem_addr_o),
      .imem_data_i (imem_data_i),
      .if_id_o     (if_id)
   );

   decode_stage u_decode (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .if_id_i   (if_id),
      .mem_wb_i  (mem_wb),
      .stall_i   (stall),
      .flush_i   (flush),
      .id_ex_o   (id_ex),
      .wb_data_o (wb_data)
   );

   execute_stage u_execute (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .id_ex_i     (id_ex),
      .fwd_a_i     (fwd_a),
      .fwd_b_i     (fwd_b),
      .ex_fwd_i    (ex_mem.alu_out),
      .wb_fwd_i    (wb_data),
      .ex_mem_o    (ex_mem),
      .br_taken_o  (br_taken),
      .br_target_o (br_target)
   );

   mem_access_unit u_mem (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .ex_mem_i     (ex_mem),
      .dmem_req_o   (dmem_req_o),
      .dmem_we_o    (dmem_we_o),
      .dmem_re_o    (dmem_re_o),
      .dmem_rdata_i (dmem_rdata_i),
      .mem_wb_o     (mem_wb)
   );

   hazard_control u_hazard (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .id_rs1_i   (if_id.instr[19:15]),  // raw fields of the decode slot
      .id_rs2_i   (if_id.instr[24:20]),
      .id_ex_i    (id_ex),
      .ex_mem_i   (ex_mem),
      .mem_wb_i   (mem_wb),
      .br_taken_i (br_taken),
      .stall_o    (stall),
      .flush_o    (flush),
      .fwd_a_o    (fwd_a),
      .fwd_b_o    (fwd_b)
   );

endmodule

/* dv/core_tb_prog.svh */
`ifndef CORE_TB_PROG_SVH
`define CORE_TB_PROG_SVH

localparam logic [6:0]  OPC_LOAD = 7'b0000011;
localparam logic [6:0]  OPC_IMM  = 7'b0010011;
localparam logic [31:0] NOP      = 32'h0000_0013;  // addi x0, x0, 0
localparam int          JAL_IDX  = 2;              // word index of the jal in its template
localparam int          N_TESTS  = 28;

typedef enum logic [3:0] {
   t_add, t_sub, t_and, t_or, t_xor, t_slt, t_addi, t_lui,
   t_ldu, t_beq, t_bne, t_jal, t_sb, t_lb, t_lbu
} tb_op_e;

typedef enum logic [2:0] {
   tpl_alu, tpl_imm, tpl_lui, tpl_ldu, tpl_branch, tpl_jal, tpl_sb, tpl_load
} tpl_e;

typedef struct packed {
   tb_op_e      op;
   logic [31:0] a;    // data word 0
   logic [31:0] b;    // data word 1, immediate or byte lane
   tpl_e        tpl;
   logic        rnd;  // operands drawn from $urandom
} test_t;

function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                      logic [4:0] rs1, logic [4:0] rs2);
   return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] opc);
   return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3);
   return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

// branch offset is in bytes, bit 0 dropped
function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs1, logic [4:0] rs2,
                                      logic [2:0] f3);
   return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(logic [20:0] off, logic [4:0] rd);
   return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd);
   return {imm, rd, 7'b0110111};
endfunction

test_t tests [0:N_TESTS-1] = '{
   '{t_add,  32'd5,          32'd7,          tpl_alu,    1'b0},
   '{t_sub,  32'd3,          32'd10,         tpl_alu,    1'b0},
   '{t_and,  32'hf0f0_f0f0,  32'h0ff0_0ff0,  tpl_alu,    1'b0},
   '{t_or,   32'hf000_000f,  32'h0123_4560,  tpl_alu,    1'b0},
   '{t_xor,  32'haaaa_5555,  32'hffff_0000,  tpl_alu,    1'b0},
   '{t_slt,  32'hffff_fffb,  32'd3,          tpl_alu,    1'b0},  // -5 < 3
   '{t_slt,  32'd3,          32'hffff_fffb,  tpl_alu,    1'b0},
   '{t_addi, 32'd100,        32'hffff_fffe,  tpl_imm,    1'b0},  // imm -2
   '{t_lui,  32'd0,          32'habcd_e000,  tpl_lui,    1'b0},
   '{t_ldu,  32'd40,         32'd2,          tpl_ldu,    1'b0},
   '{t_beq,  32'd9,          32'd9,          tpl_branch, 1'b0},
   '{t_beq,  32'd9,          32'd8,          tpl_branch, 1'b0},
   '{t_bne,  32'd9,          32'd8,          tpl_branch, 1'b0},
   '{t_bne,  32'd9,          32'd9,          tpl_branch, 1'b0},
   '{t_jal,  32'd0,          32'd0,          tpl_jal,    1'b0},
   '{t_sb,   32'h1122_3344,  32'd1,          tpl_sb,     1'b0},
   '{t_sb,   32'h5566_77a8,  32'd3,          tpl_sb,     1'b0},
   '{t_lb,   32'h12c4_5678,  32'd2,          tpl_load,   1'b0},
   '{t_lbu,  32'h12c4_5678,  32'd2,          tpl_load,   1'b0},
   '{t_lb,   32'h1234_5678,  32'd0,          tpl_load,   1'b0},
   '{t_add,  32'd0,          32'd0,          tpl_alu,    1'b1},
   '{t_add,  32'd0,          32'd0,          tpl_alu,    1'b1},
   '{t_sub,  32'd0,          32'd0,          tpl_alu,    1'b1},
   '{t_sub,  32'd0,          32'd0,          tpl_alu,    1'b1},
   '{t_xor,  32'd0,          32'd0,          tpl_alu,    1'b1},
   '{t_xor,  32'd0,          32'd0,          tpl_alu,    1'b1},
   '{t_slt,  32'd0,          32'd0,          tpl_alu,    1'b1},
   '{t_slt,  32'd0,          32'd0,          tpl_alu,    1'b1}
};

`endif

/* dv/core_tb.sv */
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

   localparam int CLK_PERIOD = 4;
   localparam int RST_CYCLES = 16;
   localparam int STORE_WAIT = 60;
   localparam int SEED       = 32'h20ac714e;

   `include "core_tb_prog.svh"

   logic        clk;
   logic        rst_n;
   logic [29:0] imem_addr;
   word_t       imem_data;
   dmem_req_t   dmem_req;
   logic        dmem_we;
   logic        dmem_re;
   word_t       dmem_rdata;
   word_t       imem [0:63];
   word_t       dmem [0:15];
   int          test_idx;

   core UUT (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .imem_addr_o  (imem_addr),
      .imem_data_i  (imem_data),
      .dmem_req_o   (dmem_req),
      .dmem_we_o    (dmem_we),
      .dmem_re_o    (dmem_re),
      .dmem_rdata_i (dmem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // single-cycle memories read combinationally
   assign imem_data  = imem[imem_addr[5:0]];
   assign dmem_rdata = dmem[dmem_req.addr[3:0]];

   always @(posedge clk) begin
      if (dmem_we) begin
         for (int l = 0; l < 4; l++) begin
            if (dmem_req.be[l])
               dmem[dmem_req.addr[3:0]][8*l +: 8] = dmem_req.wdata[8*l +: 8];
         end
      end
   end

   task automatic abort_run();
      $display("sim failed");
      $fatal(1);
   endtask

   task automatic fill_memories();
      for (int i = 0; i < 64; i++)
         imem[i] = enc_i(12'(i), 5'd0, 3'b000, 5'd0, OPC_IMM);  // nop tagged with its index
      for (int i = 0; i < 16; i++)
         dmem[i] = {16'hd00d, 16'(i)};
   endtask

   task automatic load_program(test_t t);
      logic [6:0] f7;
      logic [2:0] f3;
      f7 = (t.op == t_sub) ? 7'b0100000 : 7'b0000000;
      case (t.op)
         t_and:        f3 = 3'b111;
         t_or:         f3 = 3'b110;
         t_xor, t_lbu: f3 = 3'b100;
         t_slt:        f3 = 3'b010;
         t_bne:        f3 = 3'b001;
         default:      f3 = 3'b000;
      endcase
      imem[0] = enc_i(12'd0, 5'd0, 3'b010, 5'd1, OPC_LOAD);  // lw x1, 0(x0)
      imem[1] = enc_i(12'd4, 5'd0, 3'b010, 5'd2, OPC_LOAD);  // lw x2, 4(x0)
      case (t.tpl)
         tpl_alu: begin
            imem[2] = NOP;
            imem[3] = enc_r(f7, f3, 5'd3, 5'd1, 5'd2);         // x2 via MEM/WB
            imem[4] = enc_r(7'd0, 3'b000, 5'd4, 5'd3, 5'd0);   // x3 via EX/MEM
            imem[5] = enc_r(7'd0, 3'b000, 5'd5, 5'd0, 5'd4);
            imem[6] = enc_s(12'd8, 5'd5, 5'd0, 3'b010);
         end
         tpl_imm: begin
            imem[1] = enc_i(t.b[11:0], 5'd1, 3'b000, 5'd3, OPC_IMM);  // load-use stall
            imem[2] = enc_s(12'd8, 5'd3, 5'd0, 3'b010);
         end
         tpl_lui: begin
            imem[0] = enc_u(t.b[31:12], 5'd3);
            imem[1] = enc_s(12'd8, 5'd3, 5'd0, 3'b010);
         end
         tpl_ldu: begin
            imem[2] = enc_r(7'd0, 3'b000, 5'd3, 5'd2, 5'd1);
            imem[3] = enc_s(12'd8, 5'd3, 5'd0, 3'b010);
         end
         tpl_branch: begin
            imem[2] = NOP;
            imem[3] = enc_i(12'd1, 5'd0, 3'b000, 5'd3, OPC_IMM);
            imem[4] = enc_b(13'd16, 5'd1, 5'd2, f3);            // taken path at word 8
            imem[5] = enc_i(12'd2, 5'd0, 3'b000, 5'd3, OPC_IMM);
            imem[6] = enc_s(12'd8, 5'd3, 5'd0, 3'b010);
            imem[7] = enc_j(21'd0, 5'd0);                       // park
            imem[8] = enc_s(12'd8, 5'd3, 5'd0, 3'b010);
         end
         tpl_jal: begin
            imem[0] = NOP;
            imem[1] = NOP;
            imem[JAL_IDX] = enc_j(21'd12, 5'd5);
            imem[3] = enc_s(12'd8, 5'd0, 5'd0, 3'b010);         // skipped stores
            imem[4] = enc_s(12'd8, 5'd0, 5'd0, 3'b010);
            imem[5] = enc_s(12'd8, 5'd5, 5'd0, 3'b010);
         end
         tpl_sb: begin
            imem[1] = NOP;
            imem[2] = enc_s(12'd8 + {10'b0, t.b[1:0]}, 5'd1, 5'd0, 3'b000);
         end
         default: begin
            imem[0] = enc_i({10'b0, t.b[1:0]}, 5'd0, f3, 5'd3, OPC_LOAD);
            imem[1] = enc_s(12'd8, 5'd3, 5'd0, 3'b010);
         end
      endcase
   endtask

   // RV32I result of the operation as stored to address 8
   function automatic dmem_req_t expected_store(test_t t);
      dmem_req_t  r;
      logic [1:0] lane;
      logic [7:0] byte_v;
      lane   = t.b[1:0];
      byte_v = t.a[{lane, 3'b000} +: 8];
      r.addr = 30'd2;
      r.be   = 4'b1111;
      case (t.op)
         t_add, t_ldu: r.wdata = t.a + t.b;
         t_sub:        r.wdata = t.a - t.b;
         t_and:        r.wdata = t.a & t.b;
         t_or:         r.wdata = t.a | t.b;
         t_xor:        r.wdata = t.a ^ t.b;
         t_slt:        r.wdata = {31'b0, $signed(t.a) < $signed(t.b)};
         t_addi:       r.wdata = t.a + {{20{t.b[11]}}, t.b[11:0]};
         t_lui:        r.wdata = {t.b[31:12], 12'b0};
         t_beq:        r.wdata = (t.a == t.b) ? 32'd1 : 32'd2;
         t_bne:        r.wdata = (t.a != t.b) ? 32'd1 : 32'd2;
         t_jal:        r.wdata = word_t'(4 * JAL_IDX + 4);  // link is the next pc
         t_lb:         r.wdata = {{24{byte_v[7]}}, byte_v};
         t_lbu:        r.wdata = {24'b0, byte_v};
         default: begin
            r.be    = 4'b0001 << lane;
            r.wdata = {24'b0, t.a[7:0]} << {lane, 3'b000};
         end
      endcase
      return r;
   endfunction

   // only enabled lanes of wdata are compared
   task automatic check_store(dmem_req_t got, dmem_req_t exp);
      word_t mask;
      for (int l = 0; l < 4; l++)
         mask[8*l +: 8] = {8{exp.be[l]}};
      if (got.addr !== exp.addr || got.be !== exp.be
          || (got.wdata & mask) !== (exp.wdata & mask)) begin
         $display("ERROR %0t dmem_req_o test %0d: got addr=%h be=%b wdata=%h",
                  $time, test_idx, got.addr, got.be, got.wdata);
         $display("ERROR %0t dmem_req_o test %0d: exp addr=%h be=%b wdata=%h",
                  $time, test_idx, exp.addr, exp.be, exp.wdata);
         abort_run();
      end
   endtask

   task automatic check_fetch(logic [29:0] got, logic [29:0] exp);
      if (got !== exp) begin
         $display("ERROR %0t imem_addr_o: got %h, expected %h", $time, got, exp);
         abort_run();
      end
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("ERROR %0t %s test %0d: got %b, expected %b",
                  $time, name, test_idx, got, exp);
         abort_run();
      end
   endtask

   task automatic wait_store(output dmem_req_t req, output logic saw_read);
      bit found;
      found    = 1'b0;
      saw_read = 1'b0;
      for (int c = 0; c < STORE_WAIT && !found; c++) begin
         @(negedge clk);
         if (dmem_re)
            saw_read = 1'b1;
         if (dmem_we) begin
            req   = dmem_req;
            found = 1'b1;
         end
      end
      if (!found) begin
         $display("test %0d: no data store within %0d cycles", test_idx, STORE_WAIT);
         abort_run();
      end
   endtask

   initial begin
      test_t     t;
      dmem_req_t got;
      logic      read_seen;
      logic      uses_load;
      void'($urandom(SEED));
      rst_n    = 1'b0;
      test_idx = -1;
      fill_memories();
      repeat (RST_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      check_fetch(imem_addr, 30'd0);
      for (int c = 0; c < 20; c++) begin
         @(negedge clk);
         check_flag("dmem_we_o", dmem_we, 1'b0);  // only nops in memory
         check_flag("dmem_re_o", dmem_re, 1'b0);
      end
      for (int i = 0; i < N_TESTS; i++) begin
         test_idx = i;
         t = tests[i];
         if (t.rnd) begin
            t.a = $urandom();
            t.b = $urandom();
         end
         @(negedge clk);
         rst_n = 1'b0;
         fill_memories();
         dmem[0] = t.a;
         dmem[1] = t.b;
         load_program(t);
         repeat (RST_CYCLES) @(negedge clk);
         rst_n = 1'b1;
         wait_store(got, read_seen);
         uses_load = !(t.tpl inside {tpl_lui, tpl_jal});  // every other template loads first
         check_flag("dmem_re_o", read_seen, uses_load);
         check_store(got, expected_store(t));
      end
      $display("sim passed");
      $finish;
   end

   // run budget scales with the table length
   initial begin
      #(N_TESTS * STORE_WAIT * CLK_PERIOD);
      $display("watchdog expired before all tests finished");
      abort_run();
   end

endmodule

/* filelist.f */
+incdir+dv
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_access_unit.sv
verilog/hazard_control.sv
verilog/core.sv
dv/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= core_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard dv/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# pass only if the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(OBJ_DIR)
